/* rv_core.f */
rv_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_core.sv
rv_memory.sv
rv_top.sv
tb_rv_top.sv

/* tb_rv_top.sv */
`timescale 1ns/10ps

module tb_rv_top;

    localparam int                      mem_addr_bits = 8;
    localparam logic [rv_pkg::xlen-1:0] exit_addr     = 252;
    localparam int                      prog_words    = exit_addr / 4 + 1;
    localparam int                      max_cycles    = 200;
    localparam int                      data_base     = 'h200;
    localparam int                      res_base      = 'h300;
    localparam int                      mark_base     = 'h380;

    // branch cases with x1 = -20 and x2 = x3 = 7
    localparam logic [2:0] br_f3 [12] = '{
        rv_pkg::f3_beq,  rv_pkg::f3_beq,  rv_pkg::f3_bne,  rv_pkg::f3_bne,
        rv_pkg::f3_blt,  rv_pkg::f3_blt,  rv_pkg::f3_bge,  rv_pkg::f3_bge,
        rv_pkg::f3_bltu, rv_pkg::f3_bltu, rv_pkg::f3_bgeu, rv_pkg::f3_bgeu
    };
    localparam int br_rs1 [12]   = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    localparam int br_rs2 [12]   = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    localparam bit br_taken [12] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};

    logic                     clk;
    logic                     rst_n;
    logic                     load_we_i;
    logic [mem_addr_bits+1:0] load_addr_i;
    logic [rv_pkg::xlen-1:0]  load_data_i;
    logic [mem_addr_bits+1:0] dbg_addr_i;
    logic [rv_pkg::xlen-1:0]  dbg_rdata_o;
    logic [rv_pkg::xlen-1:0]  pc_o;
    logic                     exit_o;

    logic [rv_pkg::xlen-1:0] prog [prog_words];
    logic [rv_pkg::xlen-1:0] data_words [4];
    int                      res_addr [$];
    logic [rv_pkg::xlen-1:0] res_exp [$];
    integer                  seed;
    int                      n_inst;
    int                      res_next;
    int                      cycles;
    bit                      done;
    int                      err_word;
    int                      err_flag;
    int                      err_timeout;

    rv_top #(
        .mem_addr_bits (mem_addr_bits),
        .exit_addr     (exit_addr)
    ) i_rv_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_rdata_o (dbg_rdata_o),
        .pc_o        (pc_o),
        .exit_o      (exit_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [rv_pkg::xlen-1:0] r_type(input logic [6:0] f7,
            input logic [2:0] f3, input int rd, input int rs1, input int rs2);
        r_type = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::opc_op};
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] i_type(input logic [6:0] opc,
            input logic [2:0] f3, input int rd, input int rs1, input int imm);
        i_type = {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] s_type(input int rs2, input int rs1,
            input int imm);
        s_type = {imm[11:5], rs2[4:0], rs1[4:0], rv_pkg::f3_sw, imm[4:0], rv_pkg::opc_store};
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] b_type(input logic [2:0] f3, input int rs1,
            input int rs2, input int imm);
        b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                  rv_pkg::opc_branch};
    endfunction

    task automatic emit(input logic [rv_pkg::xlen-1:0] word);
        prog[n_inst] = word;
        n_inst++;
    endtask

    task automatic expect_word(input int addr, input logic [rv_pkg::xlen-1:0] value);
        res_addr.push_back(addr);
        res_exp.push_back(value);
    endtask

    // sw of rd to the next result slot
    task automatic store_result(input int rd, input logic [rv_pkg::xlen-1:0] value);
        emit(s_type(rd, 0, res_next));
        expect_word(res_next, value);
        res_next += 4;
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input int rs1,
            input int rs2, input logic [rv_pkg::xlen-1:0] value);
        emit(r_type(f7, f3, 5, rs1, rs2));
        store_result(5, value);
    endtask

    task automatic imm_op(input logic [2:0] f3, input int rs1, input int imm,
            input logic [rv_pkg::xlen-1:0] value);
        emit(i_type(rv_pkg::opc_op_imm, f3, 5, rs1, imm));
        store_result(5, value);
    endtask

    // filler only writes x9, which no result reads
    task automatic pad_program(input int upto);
        while (n_inst < upto) begin
            emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 9, 0, n_inst));
        end
    endtask

    task automatic build_alu_prog();
        logic [rv_pkg::xlen-1:0] a;
        logic [rv_pkg::xlen-1:0] b;
        logic [rv_pkg::xlen-1:0] c;
        logic [rv_pkg::xlen-1:0] d;
        a = data_words[0];
        b = data_words[1];
        c = data_words[2];
        d = data_words[3];
        n_inst = 0;
        res_next = res_base;
        res_addr.delete();
        res_exp.delete();
        for (int k = 0; k < 4; k++) begin
            emit(i_type(rv_pkg::opc_load, rv_pkg::f3_lw, k + 1, 0, data_base + 4 * k));
        end
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_add, 1, 2, a + b);
        reg_op(rv_pkg::f7_sub, rv_pkg::f3_add, 1, 2, a - b);
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_and, 3, 4, c & d);
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_or, 3, 4, c | d);
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_xor, 3, 4, c ^ d);
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_sll, 3, 4, c << d[4:0]);
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_srl, 1, 2, a >> b[4:0]);
        reg_op(rv_pkg::f7_sra, rv_pkg::f3_srl, 1, 2, $signed(a) >>> b[4:0]);
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_slt, 1, 2, {31'b0, $signed(a) < $signed(b)});
        reg_op(rv_pkg::f7_zero, rv_pkg::f3_sltu, 1, 2, {31'b0, a < b});
        imm_op(rv_pkg::f3_add, 1, -5, a + 32'hffff_fffb);
        imm_op(rv_pkg::f3_and, 3, -256, c & 32'hffff_ff00);
        imm_op(rv_pkg::f3_or, 2, 'h7f0, b | 32'h0000_07f0);
        imm_op(rv_pkg::f3_xor, 4, -1, ~d);
        imm_op(rv_pkg::f3_sll, 2, 28, b << 28);
        imm_op(rv_pkg::f3_srl, 1, 4, a >> 4);
        imm_op(rv_pkg::f3_srl, 1, 'h404, $signed(a) >>> 4);  // srai carries funct7 in imm
        imm_op(rv_pkg::f3_slt, 1, -19, {31'b0, $signed(a) < -19});
        imm_op(rv_pkg::f3_sltu, 2, -1, {31'b0, b < 32'hffff_ffff});
        // copies and a write to x0
        emit(i_type(rv_pkg::opc_load, rv_pkg::f3_lw, 6, 0, data_base + 8));
        store_result(6, c);
        emit(i_type(rv_pkg::opc_load, rv_pkg::f3_lw, 7, 0, data_base + 12));
        store_result(7, d);
        emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 0, 0, 123));
        store_result(0, '0);
        pad_program(prog_words - 1);
        emit(s_type(1, 0, res_base));  // sits at exit_addr and never runs
    endtask

    task automatic build_branch_prog();
        n_inst = 0;
        res_addr.delete();
        res_exp.delete();
        emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 1, 0, -20));
        emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 2, 0, 7));
        emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 3, 0, 7));
        for (int k = 0; k < 12; k++) begin
            emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 8, 0, 'h500 + k));
            emit(b_type(br_f3[k], br_rs1[k], br_rs2[k], 8));  // skips the fall marker
            emit(i_type(rv_pkg::opc_op_imm, rv_pkg::f3_add, 8, 0, 'h200 + k));
            emit(s_type(8, 0, mark_base + 4 * k));
            expect_word(mark_base + 4 * k, br_taken[k] ? 'h500 + k : 'h200 + k);
        end
        pad_program(prog_words);
    endtask

    task automatic check_word(input logic [rv_pkg::xlen-1:0] got,
            input logic [rv_pkg::xlen-1:0] exp, input string what);
        if (got !== exp) begin
            err_word++;
            $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got_exit, input logic exp_exit,
            input logic [rv_pkg::xlen-1:0] got_pc, input logic [rv_pkg::xlen-1:0] exp_pc,
            input string what);
        if (got_exit !== exp_exit || got_pc !== exp_pc) begin
            err_flag++;
            $display("ERROR %0t: %s exit_o %b pc_o 0x%08h, expected %b 0x%08h",
                     $time, what, got_exit, got_pc, exp_exit, exp_pc);
        end
    endtask

    task automatic load_word(input int addr, input logic [rv_pkg::xlen-1:0] value);
        @(posedge clk);
        #10;
        load_we_i   = 1'b1;
        load_addr_i = addr;
        load_data_i = value;
    endtask

    task automatic load_and_reset();
        @(posedge clk);
        #10 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        for (int k = 0; k < prog_words; k++) begin
            load_word(4 * k, prog[k]);
        end
        for (int k = 0; k < 4; k++) begin
            load_word(data_base + 4 * k, data_words[k]);
        end
        for (int k = 0; k < 12; k++) begin
            load_word(mark_base + 4 * k, '0);  // marker slots start empty
        end
        @(posedge clk);
        #10;
        load_we_i = 1'b0;
        check_flag(exit_o, 1'b0, pc_o, '0, "in reset");
        rst_n = 1'b1;
    endtask

    task automatic run_to_exit(output bit ok);
        cycles = 0;
        while (!exit_o && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
            #1;
        end
        ok = exit_o;
        if (!ok) begin
            err_timeout++;
            $display("timeout: exit_o did not rise within %0d cycles", max_cycles);
        end
    endtask

    task automatic read_results();
        for (int k = 0; k < res_addr.size(); k++) begin
            @(posedge clk);
            #10 dbg_addr_i = res_addr[k];
            #40 check_word(dbg_rdata_o, res_exp[k], $sformatf("mem[0x%03h]", res_addr[k]));
        end
    endtask

    initial begin
        seed        = 46;
        rst_n       = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        dbg_addr_i  = '0;
        err_word    = 0;
        err_flag    = 0;
        err_timeout = 0;
        data_words[0] = 32'hffff_ffec;  // -20
        data_words[1] = 32'd7;
        data_words[2] = $random(seed);
        data_words[3] = $random(seed);

        build_alu_prog();
        load_and_reset();
        run_to_exit(done);
        if (done) begin
            check_word(cycles, exit_addr / 4, "cycles to halt");
            read_results();
            for (int k = 0; k < 10; k++) begin
                @(posedge clk);
                #1 check_flag(exit_o, 1'b1, pc_o, exit_addr, "after halt");
            end
            read_results();  // nothing may change once halted
        end

        build_branch_prog();
        load_and_reset();
        run_to_exit(done);
        if (done) begin
            read_results();
        end

        $display("errors: %0d value, %0d flag, %0d timeout", err_word, err_flag, err_timeout);
        if (err_word + err_flag + err_timeout == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* rv_top.sv */
`timescale 1ns/10ps

module rv_top #(
    parameter int                      mem_addr_bits = 8,
    parameter logic [rv_pkg::xlen-1:0] exit_addr     = 252
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_we_i,
    input  logic [mem_addr_bits+1:0] load_addr_i,
    input  logic [rv_pkg::xlen-1:0]  load_data_i,
    input  logic [mem_addr_bits+1:0] dbg_addr_i,
    output logic [rv_pkg::xlen-1:0]  dbg_rdata_o,
    output logic [rv_pkg::xlen-1:0]  pc_o,
    output logic                     exit_o
);

    logic [mem_addr_bits+1:0] imem_addr;
    logic [rv_pkg::xlen-1:0]  imem_rdata;
    logic [mem_addr_bits+1:0] dmem_addr;
    logic [rv_pkg::xlen-1:0]  dmem_wdata;
    logic                     dmem_we;
    logic [rv_pkg::xlen-1:0]  dmem_rdata;

    rv_core #(
        .mem_addr_bits (mem_addr_bits),
        .exit_addr     (exit_addr)
    ) i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata),
        .pc_o         (pc_o),
        .exit_o       (exit_o)
    );

    rv_memory #(
        .mem_addr_bits (mem_addr_bits)
    ) i_memory (
        .clk         (clk),
        .iaddr_i     (imem_addr),
        .idata_o     (imem_rdata),
        .daddr_i     (dmem_addr),
        .dwdata_i    (dmem_wdata),
        .dwe_i       (dmem_we),
        .drdata_o    (dmem_rdata),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

endmodule

/* rv_memory.sv */
`timescale 1ns/10ps

module rv_memory #(
    parameter int mem_addr_bits = 8
) (
    input  logic                     clk,
    input  logic [mem_addr_bits+1:0] iaddr_i,
    output logic [rv_pkg::xlen-1:0]  idata_o,
    input  logic [mem_addr_bits+1:0] daddr_i,
    input  logic [rv_pkg::xlen-1:0]  dwdata_i,
    input  logic                     dwe_i,
    output logic [rv_pkg::xlen-1:0]  drdata_o,
    input  logic                     load_we_i,
    input  logic [mem_addr_bits+1:0] load_addr_i,
    input  logic [rv_pkg::xlen-1:0]  load_data_i,
    input  logic [mem_addr_bits+1:0] dbg_addr_i,
    output logic [rv_pkg::xlen-1:0]  dbg_rdata_o
);

    localparam int num_words = 2 ** mem_addr_bits;

    logic [rv_pkg::xlen-1:0]   mem [num_words];
    logic [mem_addr_bits-1:0]  iword;
    logic [mem_addr_bits-1:0]  dword;
    logic [mem_addr_bits-1:0]  lword;
    logic [mem_addr_bits-1:0]  gword;

    // word index from byte address
    assign iword = iaddr_i[mem_addr_bits+1:2];
    assign dword = daddr_i[mem_addr_bits+1:2];
    assign lword = load_addr_i[mem_addr_bits+1:2];
    assign gword = dbg_addr_i[mem_addr_bits+1:2];

    assign idata_o     = mem[iword];
    assign drdata_o    = mem[dword];
    assign dbg_rdata_o = mem[gword];

    // single write port, loader first
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem[lword] <= load_data_i;
        end else if (dwe_i) begin
            mem[dword] <= dwdata_i;
        end
    end

    // loading happens only while the core sits in reset
    a_one_writer: assert property (
        @(posedge clk) !(load_we_i && dwe_i)
    ) else $error("core store collides with loader write");

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

module rv_core #(
    parameter int                      mem_addr_bits = 8,
    parameter logic [rv_pkg::xlen-1:0] exit_addr     = 252
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [mem_addr_bits+1:0] imem_addr_o,
    input  logic [rv_pkg::xlen-1:0]  imem_rdata_i,
    output logic [mem_addr_bits+1:0] dmem_addr_o,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata_o,
    output logic                     dmem_we_o,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata_i,
    output logic [rv_pkg::xlen-1:0]  pc_o,
    output logic                     exit_o
);

    localparam logic [rv_pkg::xlen-1:0] pc_step = 4;

    logic [rv_pkg::xlen-1:0]          pc_q;
    logic [rv_pkg::xlen-1:0]          pc_next;
    logic [rv_pkg::reg_addr_bits-1:0] rs1_addr;
    logic [rv_pkg::reg_addr_bits-1:0] rs2_addr;
    logic [rv_pkg::reg_addr_bits-1:0] rd_addr;
    logic [rv_pkg::xlen-1:0]          imm_i;
    logic [rv_pkg::xlen-1:0]          imm_s;
    logic [rv_pkg::xlen-1:0]          imm_b;
    rv_pkg::alu_op_e                  alu_op;
    rv_pkg::op2_sel_e                 op2_sel;
    rv_pkg::wb_sel_e                  wb_sel;
    logic                             rf_we;
    logic                             mem_we;
    logic                             branch;
    logic [2:0]                       funct3;
    logic [rv_pkg::xlen-1:0]          rs1_data;
    logic [rv_pkg::xlen-1:0]          rs2_data;
    logic [rv_pkg::xlen-1:0]          op_b;
    logic [rv_pkg::xlen-1:0]          alu_result;
    logic [rv_pkg::xlen-1:0]          wb_data;
    logic                             branch_taken;

    rv_decoder i_decoder (
        .inst_i     (imem_rdata_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_i_o    (imm_i),
        .imm_s_o    (imm_s),
        .imm_b_o    (imm_b),
        .alu_op_o   (alu_op),
        .op2_sel_o  (op2_sel),
        .wb_sel_o   (wb_sel),
        .rf_we_o    (rf_we),
        .mem_we_o   (mem_we),
        .branch_o   (branch),
        .funct3_o   (funct3)
    );

    rv_regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we && !exit_o),  // frozen once halted
        .rd_addr_i  (rd_addr),
        .rd_data_i  (wb_data)
    );

    always_comb begin
        case (op2_sel)
            rv_pkg::op2_imm_i: op_b = imm_i;
            rv_pkg::op2_imm_s: op_b = imm_s;
            default:           op_b = rs2_data;
        endcase
    end

    rv_alu i_alu (
        .op_a_i         (rs1_data),
        .op_b_i         (op_b),
        .alu_op_i       (alu_op),
        .funct3_i       (funct3),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    assign wb_data = (wb_sel == rv_pkg::wb_mem) ? dmem_rdata_i : alu_result;
    assign pc_next = (branch && branch_taken) ? pc_q + imm_b : pc_q + pc_step;
    assign exit_o  = (pc_q == exit_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!exit_o) begin
            pc_q <= pc_next;
        end
    end

    // memory sees byte addresses cut to its own range
    assign imem_addr_o  = pc_q[mem_addr_bits+1:0];
    assign dmem_addr_o  = alu_result[mem_addr_bits+1:0];
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = mem_we && !exit_o && rst_n;  // loader owns memory during reset
    assign pc_o         = pc_q;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) (pc_q[1:0] == 2'b00)
    ) else $error("pc 0x%08h not word aligned", pc_q);

endmodule

/* rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [rv_pkg::reg_addr_bits-1:0] rs1_addr_i,
    input  logic [rv_pkg::reg_addr_bits-1:0] rs2_addr_i,
    output logic [rv_pkg::xlen-1:0]          rs1_data_o,
    output logic [rv_pkg::xlen-1:0]          rs2_data_o,
    input  logic                             we_i,
    input  logic [rv_pkg::reg_addr_bits-1:0] rd_addr_i,
    input  logic [rv_pkg::xlen-1:0]          rd_data_i
);

    localparam int num_regs = 2 ** rv_pkg::reg_addr_bits;

    logic [rv_pkg::xlen-1:0] regs [num_regs];

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin  // x0 stays hardwired
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // a write aimed at x0 must leave it at zero
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (we_i && rd_addr_i == '0) |=> (regs[0] == '0)
    ) else $error("x0 picked up a nonzero value");

endmodule

/* rv_alu.sv */
`timescale 1ns/10ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] op_a_i,
    input  logic [rv_pkg::xlen-1:0] op_b_i,
    input  rv_pkg::alu_op_e         alu_op_i,
    input  logic [2:0]              funct3_i,
    output logic [rv_pkg::xlen-1:0] result_o,
    output logic                    branch_taken_o
);

    logic [4:0] shamt;
    logic       equal;
    logic       signed_lt;
    logic       unsigned_lt;

    assign shamt       = op_b_i[4:0];
    assign equal       = (op_a_i == op_b_i);
    assign signed_lt   = ($signed(op_a_i) < $signed(op_b_i));
    assign unsigned_lt = (op_a_i < op_b_i);

    always_comb begin
        case (alu_op_i)
            rv_pkg::alu_add:  result_o = op_a_i + op_b_i;
            rv_pkg::alu_sub:  result_o = op_a_i - op_b_i;
            rv_pkg::alu_and:  result_o = op_a_i & op_b_i;
            rv_pkg::alu_or:   result_o = op_a_i | op_b_i;
            rv_pkg::alu_xor:  result_o = op_a_i ^ op_b_i;
            rv_pkg::alu_sll:  result_o = op_a_i << shamt;
            rv_pkg::alu_srl:  result_o = op_a_i >> shamt;
            rv_pkg::alu_sra:  result_o = $unsigned($signed(op_a_i) >>> shamt);
            rv_pkg::alu_slt:  result_o = {{(rv_pkg::xlen-1){1'b0}}, signed_lt};
            rv_pkg::alu_sltu: result_o = {{(rv_pkg::xlen-1){1'b0}}, unsigned_lt};
            default:          result_o = '0;
        endcase
    end

    // branch condition, qualified by branch_o in the core
    always_comb begin
        case (funct3_i)
            rv_pkg::f3_beq:  branch_taken_o = equal;
            rv_pkg::f3_bne:  branch_taken_o = !equal;
            rv_pkg::f3_blt:  branch_taken_o = signed_lt;
            rv_pkg::f3_bge:  branch_taken_o = !signed_lt;
            rv_pkg::f3_bltu: branch_taken_o = unsigned_lt;
            rv_pkg::f3_bgeu: branch_taken_o = !unsigned_lt;
            default:         branch_taken_o = 1'b0;
        endcase
    end

endmodule

/* rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0]          inst_i,
    output logic [rv_pkg::reg_addr_bits-1:0] rs1_addr_o,
    output logic [rv_pkg::reg_addr_bits-1:0] rs2_addr_o,
    output logic [rv_pkg::reg_addr_bits-1:0] rd_addr_o,
    output logic [rv_pkg::xlen-1:0]          imm_i_o,
    output logic [rv_pkg::xlen-1:0]          imm_s_o,
    output logic [rv_pkg::xlen-1:0]          imm_b_o,
    output rv_pkg::alu_op_e                  alu_op_o,
    output rv_pkg::op2_sel_e                 op2_sel_o,
    output rv_pkg::wb_sel_e                  wb_sel_o,
    output logic                             rf_we_o,
    output logic                             mem_we_o,
    output logic                             branch_o,
    output logic [2:0]                       funct3_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            f7_is_sub;
    logic            f7_is_sra;
    logic            r_f7_ok;
    logic            i_f7_ok;
    logic            is_lw;
    logic            is_sw;
    logic            is_r;
    logic            is_i;
    logic            is_branch;
    rv_pkg::alu_op_e arith_op;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];
    assign funct3_o   = funct3;

    assign imm_i_o = {{(rv_pkg::xlen-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s_o = {{(rv_pkg::xlen-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    // b-type offsets are in halfwords
    assign imm_b_o = {{(rv_pkg::xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};

    assign f7_is_sub = (funct7 == rv_pkg::f7_sub);
    assign f7_is_sra = (funct7 == rv_pkg::f7_sra);

    // only add/sub and srl/sra have a second funct7 encoding
    assign r_f7_ok = (funct7 == rv_pkg::f7_zero)
                   || (f7_is_sub && funct3 == rv_pkg::f3_add)
                   || (f7_is_sra && funct3 == rv_pkg::f3_srl);

    // immediate shifts carry funct7 in imm[11:5]
    assign i_f7_ok = (funct3 == rv_pkg::f3_sll) ? (funct7 == rv_pkg::f7_zero) :
                     (funct3 == rv_pkg::f3_srl) ? (funct7 == rv_pkg::f7_zero || f7_is_sra) :
                     1'b1;

    assign is_lw     = (opcode == rv_pkg::opc_load) && (funct3 == rv_pkg::f3_lw);
    assign is_sw     = (opcode == rv_pkg::opc_store) && (funct3 == rv_pkg::f3_sw);
    assign is_r      = (opcode == rv_pkg::opc_op) && r_f7_ok;
    assign is_i      = (opcode == rv_pkg::opc_op_imm) && i_f7_ok;
    assign is_branch = (opcode == rv_pkg::opc_branch)
                     && (funct3 == rv_pkg::f3_beq || funct3 == rv_pkg::f3_bne
                      || funct3 == rv_pkg::f3_blt || funct3 == rv_pkg::f3_bge
                      || funct3 == rv_pkg::f3_bltu || funct3 == rv_pkg::f3_bgeu);

    always_comb begin
        case (funct3)
            rv_pkg::f3_add:  arith_op = (opcode == rv_pkg::opc_op && f7_is_sub) ?
                                        rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:  arith_op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  arith_op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu: arith_op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  arith_op = rv_pkg::alu_xor;
            rv_pkg::f3_srl:  arith_op = f7_is_sra ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:   arith_op = rv_pkg::alu_or;
            rv_pkg::f3_and:  arith_op = rv_pkg::alu_and;
            default:         arith_op = rv_pkg::alu_add;
        endcase
    end

    // priority table, anything unmatched falls through as a no-op
    always_comb begin
        alu_op_o  = rv_pkg::alu_add;
        op2_sel_o = rv_pkg::op2_rs2;
        wb_sel_o  = rv_pkg::wb_alu;
        rf_we_o   = 1'b0;
        mem_we_o  = 1'b0;
        branch_o  = 1'b0;
        if (is_lw) begin
            op2_sel_o = rv_pkg::op2_imm_i;
            wb_sel_o  = rv_pkg::wb_mem;
            rf_we_o   = 1'b1;
        end else if (is_sw) begin
            op2_sel_o = rv_pkg::op2_imm_s;
            mem_we_o  = 1'b1;
        end else if (is_r) begin
            alu_op_o  = arith_op;
            rf_we_o   = 1'b1;
        end else if (is_i) begin
            alu_op_o  = arith_op;
            op2_sel_o = rv_pkg::op2_imm_i;
            rf_we_o   = 1'b1;
        end else if (is_branch) begin
            branch_o  = 1'b1;  // compares rs1 with rs2
        end
    end

endmodule

/* rv_pkg.sv */
package rv_pkg;

    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;

    // major opcodes
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // funct3, shared by register and immediate forms
    localparam logic [2:0] f3_add  = 3'b000;  // also sub
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // also sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_sw   = 3'b010;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // funct7
    localparam logic [6:0] f7_zero = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;
    localparam logic [6:0] f7_sra  = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        op2_rs2   = 2'd0,
        op2_imm_i = 2'd1,
        op2_imm_s = 2'd2
    } op2_sel_e;

    typedef enum logic {
        wb_alu = 1'b0,
        wb_mem = 1'b1
    } wb_sel_e;

endpackage
